// File: median_filter.f
+incdir+logic
logic/median_filter_pkg.sv
logic/line_buffer.sv
logic/window_gen.sv
logic/sort_stage.sv
logic/median_sorter.sv
logic/median_filter_top.sv
verif/median_filter_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the median filter testbench with Verilator, run it into a log
# and fail when the log reports a failed check

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module median_filter_tb -Mdir "$OBJ" \
    -f median_filter.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/Vmedian_filter_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    exit 1
fi
exit 0

// File: verif/median_filter_tb.sv
// ----------------------------------------------------------
// testbench for the 5x5 median filter with random and
// pattern frames checked against a sorting model
// ----------------------------------------------------------

`default_nettype none

`include "median_filter_defines.svh"

module median_filter_tb;

    localparam int FRAME_W       = 12;
    localparam int FRAME_H       = 8;
    localparam int DIM           = `MF_KERNEL_DIM;
    localparam int HALF          = DIM / 2;
    localparam int OUT_W         = FRAME_W - DIM + 1;
    localparam int OUT_H         = FRAME_H - DIM + 1;
    localparam int LATENCY       = 17;
    localparam int LINE_GAP      = 3;
    localparam int NUM_FRAMES    = 5;
    localparam int DRAIN_TIMEOUT = 200;

    localparam int FRAME_RANDOM  = 0;
    localparam int FRAME_MAX     = 1;
    localparam int FRAME_STRIPES = 2;

    localparam median_filter_pkg::pixel_t PIX_MAX = '1;

    logic                      clk = 1'b0;
    logic                      rst_i;
    median_filter_pkg::pixel_t pix_i;
    logic                      de_i;
    logic                      hs_i;
    logic                      vs_i;
    median_filter_pkg::pixel_t do_o;
    median_filter_pkg::pixel_t bypass_o;
    logic                      de_o;
    logic                      hs_o;
    logic                      vs_o;

    // expected de driven next to the stimulus
    logic                      exp_win;
    logic [LATENCY-1:0]        de_pipe = '0;
    logic [LATENCY-1:0]        hs_pipe = '0;
    logic [LATENCY-1:0]        vs_pipe = '0;
    logic                      chk_en = 1'b0;
    logic [15:0]               lfsr_state = 16'd34640;

    median_filter_pkg::pixel_t frame_pix [FRAME_H][FRAME_W];
    median_filter_pkg::pixel_t exp_med_q [$];
    median_filter_pkg::pixel_t exp_byp_q [$];
    int                        frame_out_q [$];

    int   err_data = 0;
    int   err_sync = 0;
    int   err_frame = 0;
    int   err_timeout = 0;
    int   out_line_pix = 0;
    int   out_lines = 0;
    int   out_frame_pix = 0;
    logic frame_open = 1'b0;
    logic de_o_q = 1'b0;
    logic timed_out;

    always #4 clk = ~clk;

    median_filter_top i_median_filter_top (
        .clk      (clk),
        .rst_i    (rst_i),
        .pix_i    (pix_i),
        .de_i     (de_i),
        .hs_i     (hs_i),
        .vs_i     (vs_i),
        .do_o     (do_o),
        .de_o     (de_o),
        .hs_o     (hs_o),
        .vs_o     (vs_o),
        .bypass_o (bypass_o)
    );

    // ------------------------------------------------------------
    // stimulus and model helpers
    // ------------------------------------------------------------
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic next_pixel(output median_filter_pkg::pixel_t p);
        for (int b = 0; b < `MF_PIXEL_WIDTH; b++) begin
            p[b] = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // 13th smallest of the neighbourhood ending at row r and column c
    function automatic median_filter_pkg::pixel_t window_median(int r, int c);
        median_filter_pkg::pixel_t vals [DIM*DIM];
        median_filter_pkg::pixel_t t;
        for (int dr = 0; dr < DIM; dr++) begin
            for (int dc = 0; dc < DIM; dc++) begin
                vals[dr*DIM+dc] = frame_pix[r-DIM+1+dr][c-DIM+1+dc];
            end
        end
        for (int i = 1; i < DIM*DIM; i++) begin
            for (int j = i; j > 0; j--) begin
                if (vals[j-1] > vals[j]) begin
                    t = vals[j];
                    vals[j] = vals[j-1];
                    vals[j-1] = t;
                end
            end
        end
        return vals[(DIM*DIM)/2];
    endfunction

    task automatic build_frame(input int kind);
        for (int r = 0; r < FRAME_H; r++) begin
            for (int c = 0; c < FRAME_W; c++) begin
                if (kind == FRAME_RANDOM) begin
                    next_pixel(frame_pix[r][c]);
                end else if (kind == FRAME_MAX) begin
                    frame_pix[r][c] = PIX_MAX;
                end else begin
                    frame_pix[r][c] = (c % 2 == 1) ? PIX_MAX : '0;
                end
            end
        end
        for (int r = DIM - 1; r < FRAME_H; r++) begin
            for (int c = DIM - 1; c < FRAME_W; c++) begin
                exp_med_q.push_back(window_median(r, c));
                exp_byp_q.push_back(frame_pix[r-HALF][c-HALF]);
            end
        end
    endtask

    task automatic drive_gap(input logic hs);
        @(posedge clk);
        vs_i    <= 1'b0;
        de_i    <= 1'b0;
        hs_i    <= hs;
        pix_i   <= '0;
        exp_win <= 1'b0;
    endtask

    // vs pulse then lines with a three-cycle gap before each
    task automatic drive_frame();
        @(posedge clk);
        vs_i    <= 1'b1;
        de_i    <= 1'b0;
        hs_i    <= 1'b0;
        exp_win <= 1'b0;
        for (int r = 0; r < FRAME_H; r++) begin
            for (int g = 0; g < LINE_GAP; g++) begin
                drive_gap(g == 0);
            end
            for (int c = 0; c < FRAME_W; c++) begin
                @(posedge clk);
                hs_i    <= 1'b0;
                de_i    <= 1'b1;
                pix_i   <= frame_pix[r][c];
                exp_win <= (r >= DIM - 1) && (c >= DIM - 1);
            end
        end
        for (int g = 0; g < LINE_GAP; g++) begin
            drive_gap(1'b0);
        end
    endtask

    task automatic check_quiet(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            assert ({de_o, hs_o, vs_o} === 3'b000) else begin
                err_sync++;
                $display("FAIL %0t {de_o,hs_o,vs_o} got %b expected 000",
                         $time, {de_o, hs_o, vs_o});
            end
        end
    endtask

    task automatic wait_for_drain(output logic expired);
        int n;
        n = 0;
        while (exp_med_q.size() != 0 && n < DRAIN_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        expired = (exp_med_q.size() != 0);
    endtask

    // ------------------------------------------------------------
    // output checking
    // ------------------------------------------------------------
    always @(posedge clk) begin
        de_pipe <= {de_pipe[LATENCY-2:0], exp_win};
        hs_pipe <= {hs_pipe[LATENCY-2:0], hs_i};
        vs_pipe <= {vs_pipe[LATENCY-2:0], vs_i};
    end

    a_de_delay: assert property (@(posedge clk) disable iff (!chk_en)
        de_o == de_pipe[LATENCY-1])
        else begin
            err_sync++;
            $display("FAIL %0t de_o got %b expected %b",
                     $time, $sampled(de_o), $sampled(de_pipe[LATENCY-1]));
        end

    a_hs_delay: assert property (@(posedge clk) disable iff (!chk_en)
        hs_o == hs_pipe[LATENCY-1])
        else begin
            err_sync++;
            $display("FAIL %0t hs_o got %b expected %b",
                     $time, $sampled(hs_o), $sampled(hs_pipe[LATENCY-1]));
        end

    a_vs_delay: assert property (@(posedge clk) disable iff (!chk_en)
        vs_o == vs_pipe[LATENCY-1])
        else begin
            err_sync++;
            $display("FAIL %0t vs_o got %b expected %b",
                     $time, $sampled(vs_o), $sampled(vs_pipe[LATENCY-1]));
        end

    task automatic compare_output();
        median_filter_pkg::pixel_t med;
        median_filter_pkg::pixel_t byp;
        if (exp_med_q.size() == 0) begin
            err_data++;
            $display("output pixel at %0t with no window waiting for it", $time);
        end else begin
            med = exp_med_q.pop_front();
            byp = exp_byp_q.pop_front();
            assert (do_o == med) else begin
                err_data++;
                $display("FAIL %0t do_o got %h expected %h", $time, do_o, med);
            end
            assert (bypass_o == byp) else begin
                err_data++;
                $display("FAIL %0t bypass_o got %h expected %h", $time, bypass_o, byp);
            end
        end
    endtask

    task automatic end_output_line();
        assert (out_line_pix == OUT_W) else begin
            err_frame++;
            $display("FAIL %0t output line length got %0d expected %0d",
                     $time, out_line_pix, OUT_W);
        end
        out_lines++;
        out_frame_pix += out_line_pix;
        out_line_pix = 0;
    endtask

    task automatic end_output_frame();
        if (frame_open) begin
            assert (out_lines == OUT_H) else begin
                err_frame++;
                $display("FAIL %0t output lines per frame got %0d expected %0d",
                         $time, out_lines, OUT_H);
            end
            frame_out_q.push_back(out_frame_pix);
        end
        out_lines = 0;
        out_frame_pix = 0;
    endtask

    always @(negedge clk) begin
        if (chk_en) begin
            if (vs_o) begin
                end_output_frame();
                frame_open = 1'b1;
            end
            if (de_o) begin
                compare_output();
                out_line_pix++;
            end else if (de_o_q) begin
                end_output_line();
            end
            de_o_q = de_o;
        end
    end

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        rst_i   = 1'b1;
        pix_i   = '0;
        de_i    = 1'b0;
        hs_i    = 1'b0;
        vs_i    = 1'b0;
        exp_win = 1'b0;
        repeat (16) @(posedge clk);
        rst_i  <= 1'b0;
        chk_en <= 1'b1;

        check_quiet(24);

        build_frame(FRAME_RANDOM);
        drive_frame();
        build_frame(FRAME_MAX);
        drive_frame();
        build_frame(FRAME_STRIPES);
        drive_frame();
        // back-to-back random frames restart the row state on vs
        build_frame(FRAME_RANDOM);
        drive_frame();
        build_frame(FRAME_RANDOM);
        drive_frame();

        wait_for_drain(timed_out);
        if (timed_out) begin
            err_timeout++;
            $display("timeout: %0d expected output pixels never appeared",
                     exp_med_q.size());
        end else begin
            repeat (4) @(negedge clk);
            @(posedge clk);
            end_output_frame();
            assert (frame_out_q.size() == NUM_FRAMES) else begin
                err_frame++;
                $display("FAIL %0t output frames got %0d expected %0d",
                         $time, frame_out_q.size(), NUM_FRAMES);
            end
            foreach (frame_out_q[i]) begin
                assert (frame_out_q[i] == OUT_W * OUT_H) else begin
                    err_frame++;
                    $display("FAIL %0t frame %0d output pixels got %0d expected %0d",
                             $time, i, frame_out_q[i], OUT_W * OUT_H);
                end
            end
            // the frame that directly follows a complete one against the first frame
            if (frame_out_q.size() >= 2) begin
                assert (frame_out_q[1] == frame_out_q[0]) else begin
                    err_frame++;
                    $display("FAIL %0t second frame output pixels got %0d expected %0d",
                             $time, frame_out_q[1], frame_out_q[0]);
                end
            end
        end

        $display("errors: data %0d, sync %0d, framing %0d, timeout %0d",
                 err_data, err_sync, err_frame, err_timeout);
        if (err_data + err_sync + err_frame + err_timeout == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/median_filter_top.sv
// ----------------------------------------------------------
// 5x5 median filter top, window generator feeding the
// pipelined sorter, 17 cycles from pixel to median
// ----------------------------------------------------------

`default_nettype none

module median_filter_top (
    input  wire                          clk,
    input  wire                          rst_i,
    input  median_filter_pkg::pixel_t    pix_i,
    input  wire                          de_i,
    input  wire                          hs_i,
    input  wire                          vs_i,
    output median_filter_pkg::pixel_t    do_o,
    output wire                          de_o,
    output wire                          hs_o,
    output wire                          vs_o,
    output median_filter_pkg::pixel_t    bypass_o
);

    median_filter_pkg::window_t win;
    wire                        win_de;
    wire                        win_hs;
    wire                        win_vs;

    window_gen i_window_gen (
        .clk      (clk),
        .rst_i    (rst_i),
        .pix_i    (pix_i),
        .de_i     (de_i),
        .hs_i     (hs_i),
        .vs_i     (vs_i),
        .win_o    (win),
        .win_de_o (win_de),
        .win_hs_o (win_hs),
        .win_vs_o (win_vs)
    );

    // output resolution (X-4) * (Y-4)
    median_sorter i_median_sorter (
        .clk      (clk),
        .rst_i    (rst_i),
        .win_i    (win),
        .win_de_i (win_de),
        .win_hs_i (win_hs),
        .win_vs_i (win_vs),
        .med_o    (do_o),
        .centre_o (bypass_o),
        .de_o     (de_o),
        .hs_o     (hs_o),
        .vs_o     (vs_o)
    );

endmodule

`default_nettype wire

// File: logic/median_sorter.sv
// ----------------------------------------------------------
// median sorter: 15 network stages in a chain, with the
// centre pixel and sync bits delayed alongside
// ----------------------------------------------------------

`default_nettype none

`include "median_filter_defines.svh"

module median_sorter (
    input  wire                          clk,
    input  wire                          rst_i,
    input  median_filter_pkg::window_t   win_i,
    input  wire                          win_de_i,
    input  wire                          win_hs_i,
    input  wire                          win_vs_i,
    output median_filter_pkg::pixel_t    med_o,
    output median_filter_pkg::pixel_t    centre_o,
    output logic                         de_o,
    output logic                         hs_o,
    output logic                         vs_o
);

    localparam int N   = `MF_SORT_STAGES;
    localparam int MID = `MF_KERNEL_SIZE / 2;

    wire median_filter_pkg::window_t lanes [N+1];

    median_filter_pkg::pixel_t centre_sr [N];
    logic [N-1:0]              de_sr;
    logic [N-1:0]              hs_sr;
    logic [N-1:0]              vs_sr;

    assign lanes[0] = win_i;

    // ------------------------------------------------------------
    // compare-exchange network
    // ------------------------------------------------------------
    for (genvar s = 0; s < N; s++) begin : g_stage
        sort_stage #(
            .STAGE (s)
        ) i_sort_stage (
            .clk     (clk),
            .lanes_i (lanes[s]),
            .lanes_o (lanes[s+1])
        );
    end

    // middle of the sorted lanes
    assign med_o = lanes[N][MID];

    // ------------------------------------------------------------
    // matching delay
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        centre_sr[0] <= win_i[MID];
        for (int i = 1; i < N; i++) begin
            centre_sr[i] <= centre_sr[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            de_sr <= '0;
            hs_sr <= '0;
            vs_sr <= '0;
        end else begin
            de_sr <= {de_sr[N-2:0], win_de_i};
            hs_sr <= {hs_sr[N-2:0], win_hs_i};
            vs_sr <= {vs_sr[N-2:0], win_vs_i};
        end
    end

    assign centre_o = centre_sr[N-1];
    assign de_o     = de_sr[N-1];
    assign hs_o     = hs_sr[N-1];
    assign vs_o     = vs_sr[N-1];

endmodule

`default_nettype wire

// File: logic/sort_stage.sv
// ----------------------------------------------------------
// one registered stage of the odd-even merge network,
// 32-lane Batcher rule pruned to 25 lanes
// ----------------------------------------------------------

`default_nettype none

`include "median_filter_defines.svh"

module sort_stage #(
    parameter int STAGE = 0
) (
    input  wire                          clk,
    input  median_filter_pkg::window_t   lanes_i,
    output median_filter_pkg::window_t   lanes_o
);

    localparam int NET_LANES = 32;
    localparam int NET_LOG2  = 5;
    localparam int LANES     = `MF_KERNEL_SIZE;

    // merge level p = 2**t, stages of level t start at t*(t+1)/2
    function automatic int stage_level(int s);
        int t;
        t = 0;
        for (int i = 1; i < NET_LOG2; i++) begin
            if (i * (i + 1) / 2 <= s) begin
                t = i;
            end
        end
        return t;
    endfunction

    function automatic int stage_dist(int s);
        int t;
        t = stage_level(s);
        return 1 << (t - (s - t * (t + 1) / 2));
    endfunction

    // lane l compares with l+k and keeps the smaller
    function automatic bit is_low(int s, int l);
        int k;
        int p;
        int j0;
        k  = stage_dist(s);
        p  = 1 << stage_level(s);
        j0 = k % p;
        return (l >= j0) && (((l - j0) % (2 * k)) < k) && (l + k < NET_LANES)
            && ((l / (2 * p)) == ((l + k) / (2 * p)));
    endfunction

    function automatic median_filter_pkg::cx_op_e lane_op(int s, int l);
        int k;
        k = stage_dist(s);
        if (is_low(s, l) && (l + k < LANES)) begin
            return median_filter_pkg::CX_LOW;
        end else if ((l >= k) && is_low(s, l - k)) begin
            return median_filter_pkg::CX_HIGH;
        end
        return median_filter_pkg::CX_PASS;
    endfunction

    localparam int K = stage_dist(STAGE);

    wire median_filter_pkg::window_t lanes_d;

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        localparam median_filter_pkg::cx_op_e OP = lane_op(STAGE, l);
        localparam int PART = (OP == median_filter_pkg::CX_LOW)  ? l + K :
                              (OP == median_filter_pkg::CX_HIGH) ? l - K : l;

        if (OP == median_filter_pkg::CX_LOW) begin : g_low
            assign lanes_d[l] = (lanes_i[l] <= lanes_i[PART]) ? lanes_i[l] : lanes_i[PART];
        end else if (OP == median_filter_pkg::CX_HIGH) begin : g_high
            assign lanes_d[l] = (lanes_i[l] >= lanes_i[PART]) ? lanes_i[l] : lanes_i[PART];
        end else begin : g_pass
            assign lanes_d[l] = lanes_i[PART];
        end
    end

    always_ff @(posedge clk) begin
        lanes_o <= lanes_d;
    end

endmodule

`default_nettype wire

// File: logic/window_gen.sv
// ----------------------------------------------------------
// window generator: tracks column and row position and
// builds a qualified 5x5 window from the line buffer
// ----------------------------------------------------------

`default_nettype none

`include "median_filter_defines.svh"

module window_gen (
    input  wire                          clk,
    input  wire                          rst_i,
    input  median_filter_pkg::pixel_t    pix_i,
    input  wire                          de_i,
    input  wire                          hs_i,
    input  wire                          vs_i,
    output median_filter_pkg::window_t   win_o,
    output logic                         win_de_o,
    output logic                         win_hs_o,
    output logic                         win_vs_o
);

    localparam int DIM = `MF_KERNEL_DIM;
    localparam int LAT = `MF_WIN_LATENCY;

    median_filter_pkg::col_addr_t  col_cnt;
    median_filter_pkg::row_state_e row_state;
    median_filter_pkg::column_t    lb_col;
    logic [2:0]                    line_cnt;
    logic                          line_de_q;
    logic                          line_end;
    logic                          win_ok;
    logic [LAT-1:0]                de_sr;
    logic [LAT-1:0]                hs_sr;
    logic [LAT-1:0]                vs_sr;

    line_buffer i_line_buffer (
        .clk     (clk),
        .wr_en_i (de_i),
        .col_i   (col_cnt),
        .pix_i   (pix_i),
        .col_o   (lb_col)
    );

    assign line_end = line_de_q & ~de_i;

    // complete window: fifth column onward of a line in ROW_RUN
    assign win_ok = de_i
                  && (col_cnt >= median_filter_pkg::col_addr_t'(DIM - 1))
                  && (row_state == median_filter_pkg::ROW_RUN);

    // ------------------------------------------------------------
    // position tracking
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            col_cnt   <= '0;
            line_de_q <= 1'b0;
            line_cnt  <= '0;
            row_state <= median_filter_pkg::ROW_IDLE;
        end else begin
            line_de_q <= de_i;
            if (de_i) begin
                col_cnt <= col_cnt + 1'b1;
            end else begin
                col_cnt <= '0;
            end

            if (vs_i) begin
                line_cnt  <= '0;
                row_state <= median_filter_pkg::ROW_FILL;
            end else if (line_end && row_state == median_filter_pkg::ROW_FILL) begin
                // four stored lines make the next one usable
                if (line_cnt == 3'(DIM - 2)) begin
                    row_state <= median_filter_pkg::ROW_RUN;
                end else begin
                    line_cnt <= line_cnt + 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // window shift, newest column enters at the right
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (line_de_q) begin
            for (int r = 0; r < DIM; r++) begin
                for (int c = 0; c < DIM - 1; c++) begin
                    win_o[r*DIM+c] <= win_o[r*DIM+c+1];
                end
                win_o[r*DIM+DIM-1] <= lb_col[r];
            end
        end
    end

    // sync delay matching the window path
    always_ff @(posedge clk) begin
        if (rst_i) begin
            de_sr <= '0;
            hs_sr <= '0;
            vs_sr <= '0;
        end else begin
            de_sr <= {de_sr[LAT-2:0], win_ok};
            hs_sr <= {hs_sr[LAT-2:0], hs_i};
            vs_sr <= {vs_sr[LAT-2:0], vs_i};
        end
    end

    assign win_de_o = de_sr[LAT-1];
    assign win_hs_o = hs_sr[LAT-1];
    assign win_vs_o = vs_sr[LAT-1];

endmodule

`default_nettype wire

// File: logic/line_buffer.sv
// ----------------------------------------------------------
// four cascaded line memories, one pixel in and a
// five-pixel vertical column out
// ----------------------------------------------------------

`default_nettype none

`include "median_filter_defines.svh"

module line_buffer (
    input  wire                           clk,
    input  wire                           wr_en_i,
    input  median_filter_pkg::col_addr_t  col_i,
    input  median_filter_pkg::pixel_t     pix_i,
    output median_filter_pkg::column_t    col_o
);

    localparam int LINES = `MF_KERNEL_DIM - 1;

    // line_mem[LINES-1] holds the previous line, line_mem[0] the oldest
    median_filter_pkg::pixel_t line_mem [LINES][`MF_LINE_SIZE_MAX];

    // ------------------------------------------------------------
    // read old column, then push every pixel one line down
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            for (int m = 0; m < LINES; m++) begin
                col_o[m] <= line_mem[m][col_i];
            end
            col_o[LINES] <= pix_i;

            for (int m = 0; m < LINES - 1; m++) begin
                line_mem[m][col_i] <= line_mem[m+1][col_i];
            end
            line_mem[LINES-1][col_i] <= pix_i;
        end
    end

endmodule

`default_nettype wire

// File: logic/median_filter_pkg.sv
// ----------------------------------------------------------
// median filter types: pixel, column, window and the
// enums for row tracking and network lane roles
// ----------------------------------------------------------

`default_nettype none

`include "median_filter_defines.svh"

package median_filter_pkg;

    typedef logic [`MF_PIXEL_WIDTH-1:0] pixel_t;
    typedef logic [`MF_COL_WIDTH-1:0] col_addr_t;

    // index 0 is the oldest line
    typedef pixel_t [`MF_KERNEL_DIM-1:0] column_t;

    // raster order, row*5 + col, index 12 is the centre
    typedef pixel_t [`MF_KERNEL_SIZE-1:0] window_t;

    typedef enum logic [1:0] {
        ROW_IDLE = 2'd0,
        ROW_FILL = 2'd1,
        ROW_RUN  = 2'd2
    } row_state_e;

    typedef enum logic [1:0] {
        CX_PASS = 2'd0,
        CX_LOW  = 2'd1,
        CX_HIGH = 2'd2
    } cx_op_e;

endpackage

`default_nettype wire

// File: logic/median_filter_defines.svh
// ----------------------------------------------------------
// median filter sizing: pixel width, line memory depth,
// kernel geometry and pipeline depths
// ----------------------------------------------------------

`ifndef MEDIAN_FILTER_DEFINES_SVH
`define MEDIAN_FILTER_DEFINES_SVH

// pixel and line geometry
`define MF_PIXEL_WIDTH   12
`define MF_LINE_SIZE_MAX 64
`define MF_COL_WIDTH     6

// 5x5 kernel
`define MF_KERNEL_DIM    5
`define MF_KERNEL_SIZE   25

// pipeline depths
`define MF_SORT_STAGES   15
`define MF_WIN_LATENCY   2

`endif
